//--- source/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// tag 0 is reserved for "no dependency"
`define LSU_TAG_W 4
`define LSU_ENTRIES (1 << `LSU_TAG_W)

// data memory depth in 32-bit words
`define LSU_MEM_WORDS 256

// cycles per memory access (at least 1)
`define LSU_MEM_LATENCY 3

`endif

//--- source/lsuPkg.sv
`include "lsu_config.svh"

package lsuPkg;

    typedef logic [`LSU_TAG_W-1:0] tagT;
    typedef logic [31:0] wordT;

    typedef enum logic [3:0] {
        opNone,
        opLb,
        opLh,
        opLw,
        opLbu,
        opLhu,
        opSb,
        opSh,
        opSw
    } memOpE;

    // tag of 0 means data is already valid
    typedef struct packed {
        tagT  tag;
        wordT data;
    } srcS;

    typedef struct packed {
        logic  valid;
        memOpE op;
        tagT   tag;
        wordT  imm;
        srcS   base;
        srcS   storeData;
    } dispatchS;

    typedef struct packed {
        logic valid;
        tagT  tag;
        wordT data;
    } resultS;

    typedef struct packed {
        logic  valid;
        memOpE op;
        tagT   tag;
        wordT  addr;
        wordT  data;
    } memReqS;

    function automatic logic isStore(memOpE op);
        return op inside {opSb, opSh, opSw};
    endfunction

endpackage

//--- source/latencyTimer.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module latencyTimer (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    output logic done
);

    localparam int CntW = $clog2(`LSU_MEM_LATENCY + 1);

    logic [CntW-1:0] count;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                count <= CntW'(`LSU_MEM_LATENCY);
            end else if (count != '0) begin
                count <= count - 1'b1;
                // last cycle of the access
                if (count == CntW'(1)) begin
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- source/dataMemory.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module dataMemory (
    input  logic                              clk,
    input  logic                              memEn,
    input  logic                              memWe,
    input  logic [3:0]                        memByteEn,
    input  logic [$clog2(`LSU_MEM_WORDS)-1:0] memAddr,
    input  lsuPkg::wordT                      memWdata,
    output lsuPkg::wordT                      memRdata
);
    import lsuPkg::*;

    wordT mem [`LSU_MEM_WORDS];

    initial begin
        for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (memEn) begin
            if (memWe) begin
                // byte-masked write
                for (int b = 0; b < 4; b++) begin
                    if (memByteEn[b]) begin
                        mem[memAddr][8*b +: 8] <= memWdata[8*b +: 8];
                    end
                end
            end else begin
                memRdata <= mem[memAddr];
            end
        end
    end

endmodule

//--- source/memAccessFsm.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module memAccessFsm (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              flush,
    input  lsuPkg::memReqS                    memReq,
    input  logic                              done,
    output logic                              start,
    output logic                              memBusy,
    output logic                              memIdle,
    output logic                              memEn,
    output logic                              memWe,
    output logic [3:0]                        memByteEn,
    output logic [$clog2(`LSU_MEM_WORDS)-1:0] memAddr,
    output lsuPkg::wordT                      memWdata,
    input  lsuPkg::wordT                      memRdata,
    output lsuPkg::resultS                    loadResult
);
    import lsuPkg::*;

    localparam int AddrW = $clog2(`LSU_MEM_WORDS);

    typedef enum logic [1:0] {
        stIdle,
        stWait,
        stRead,
        stRespond
    } stateE;

    stateE state;
    logic  killed;

    // latched request
    memOpE reqOp;
    tagT   reqTag;
    wordT  reqAddr;
    wordT  reqData;

    wordT laneWord;
    wordT loadData;

    assign start   = (state == stIdle) && memReq.valid;
    assign memBusy = (state != stIdle);
    assign memIdle = (state == stIdle) && !memReq.valid;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= stIdle;
            killed <= 1'b0;
        end else begin
            if (flush) begin
                killed <= 1'b1;
            end
            case (state)
                stIdle: begin
                    killed <= flush;
                    if (memReq.valid) begin
                        state <= stWait;
                    end
                end
                stWait: begin
                    if (done) begin
                        state <= isStore(reqOp) ? stRespond : stRead;
                    end
                end
                stRead:    state <= stRespond;
                default:   state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            reqOp   <= memReq.op;
            reqTag  <= memReq.tag;
            reqAddr <= memReq.addr;
            reqData <= memReq.data;
        end
    end

    // access fires when the timer expires
    assign memEn    = (state == stWait) && done;
    assign memWe    = memEn && isStore(reqOp);
    assign memAddr  = reqAddr[AddrW+1:2];
    assign memWdata = reqData << {reqAddr[1:0], 3'b000};

    always_comb begin
        case (reqOp)
            opSb:    memByteEn = 4'b0001 << reqAddr[1:0];
            opSh:    memByteEn = 4'b0011 << {reqAddr[1], 1'b0};
            default: memByteEn = 4'b1111;
        endcase
    end

    // move the addressed lane down to bit 0
    assign laneWord = memRdata >> {reqAddr[1:0], 3'b000};

    always_comb begin
        case (reqOp)
            opLb:    loadData = {{24{laneWord[7]}}, laneWord[7:0]};
            opLbu:   loadData = {24'd0, laneWord[7:0]};
            opLh:    loadData = {{16{laneWord[15]}}, laneWord[15:0]};
            opLhu:   loadData = {16'd0, laneWord[15:0]};
            default: loadData = laneWord;
        endcase
    end

    // read data is valid the cycle after done
    assign loadResult.valid = (state == stRead) && !killed && !flush;
    assign loadResult.tag   = reqTag;
    assign loadResult.data  = loadData;

endmodule

//--- source/loadStoreBuffer.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module loadStoreBuffer (
    input  logic             clk,
    input  logic             rstN,
    input  logic             flush,
    input  lsuPkg::dispatchS dispatch,
    input  lsuPkg::resultS   exResult,
    input  lsuPkg::resultS   loadResult,
    input  logic             commitValid,
    input  lsuPkg::tagT      commitTag,
    input  logic             memBusy,
    output lsuPkg::memReqS   memReq,
    output logic             full,
    output logic             bufEmpty
);
    import lsuPkg::*;

    localparam int Entries = `LSU_ENTRIES;

    // per-entry control state
    logic [Entries-1:0] occupied;
    logic [Entries-1:0] issued;
    logic [Entries-1:0] committed;
    logic [Entries-1:0] baseRdy;
    logic [Entries-1:0] dataRdy;

    // per-entry payload
    memOpE entOp   [Entries];
    wordT  entImm  [Entries];
    srcS   entBase [Entries];
    srcS   entData [Entries];

    logic dispatchOk;
    logic storeFound;
    logic loadFound;
    tagT  storeSel;
    tagT  loadSel;
    tagT  sel;
    logic canIssue;

    // operand matches either broadcast
    function automatic logic srcHit(srcS s, resultS a, resultS b);
        return (s.tag != '0) && ((a.valid && s.tag == a.tag) || (b.valid && s.tag == b.tag));
    endfunction

    function automatic wordT srcValue(srcS s, resultS a, resultS b);
        if (s.tag != '0 && a.valid && s.tag == a.tag) begin
            return a.data;
        end
        if (s.tag != '0 && b.valid && s.tag == b.tag) begin
            return b.data;
        end
        return s.data;
    endfunction

    assign dispatchOk = dispatch.valid && (dispatch.op != opNone);

    // entry 0 is never allocated
    assign full     = &occupied[Entries-1:1];
    assign bufEmpty = ~|occupied;

    // lowest committed store wins over the lowest ready load
    always_comb begin
        storeFound = 1'b0;
        loadFound  = 1'b0;
        storeSel   = '0;
        loadSel    = '0;
        for (int i = 1; i < Entries; i++) begin
            if (!storeFound && occupied[i] && committed[i] && baseRdy[i] && dataRdy[i]
                    && isStore(entOp[i])) begin
                storeFound = 1'b1;
                storeSel   = tagT'(i);
            end
            if (!loadFound && occupied[i] && !issued[i] && baseRdy[i]
                    && !isStore(entOp[i])) begin
                loadFound = 1'b1;
                loadSel   = tagT'(i);
            end
        end
        sel = storeFound ? storeSel : loadSel;
    end

    // own pending request blocks until the FSM has taken it
    assign canIssue = (storeFound || loadFound) && !memBusy && !memReq.valid;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            occupied  <= '0;
            issued    <= '0;
            committed <= '0;
            baseRdy   <= '0;
            dataRdy   <= '0;
            memReq    <= '0;
        end else if (flush) begin
            occupied     <= '0;
            issued       <= '0;
            committed    <= '0;
            baseRdy      <= '0;
            dataRdy      <= '0;
            memReq.valid <= 1'b0;
        end else begin
            for (int i = 1; i < Entries; i++) begin
                if (!baseRdy[i] && srcHit(entBase[i], exResult, loadResult)) begin
                    baseRdy[i] <= 1'b1;
                end
                if (!dataRdy[i] && srcHit(entData[i], exResult, loadResult)) begin
                    dataRdy[i] <= 1'b1;
                end
            end

            if (commitValid && occupied[commitTag] && isStore(entOp[commitTag])) begin
                committed[commitTag] <= 1'b1;
            end

            // load completes and releases its entry
            if (loadResult.valid) begin
                occupied[loadResult.tag] <= 1'b0;
            end

            memReq.valid <= 1'b0;
            if (canIssue) begin
                memReq.valid <= 1'b1;
                memReq.op    <= entOp[sel];
                memReq.tag   <= sel;
                memReq.addr  <= entBase[sel].data + entImm[sel];
                memReq.data  <= entData[sel].data;
                if (isStore(entOp[sel])) begin
                    occupied[sel] <= 1'b0;
                end else begin
                    issued[sel] <= 1'b1;
                end
            end

            if (dispatchOk) begin
                occupied[dispatch.tag]  <= 1'b1;
                issued[dispatch.tag]    <= 1'b0;
                committed[dispatch.tag] <= 1'b0;
                baseRdy[dispatch.tag]   <= (dispatch.base.tag == '0)
                    || srcHit(dispatch.base, exResult, loadResult);
                dataRdy[dispatch.tag]   <= (dispatch.storeData.tag == '0)
                    || srcHit(dispatch.storeData, exResult, loadResult);
            end
        end
    end

    // operand values use the same tag match as the ready flags
    always_ff @(posedge clk) begin
        for (int i = 1; i < Entries; i++) begin
            if (!baseRdy[i] && srcHit(entBase[i], exResult, loadResult)) begin
                entBase[i].data <= srcValue(entBase[i], exResult, loadResult);
            end
            if (!dataRdy[i] && srcHit(entData[i], exResult, loadResult)) begin
                entData[i].data <= srcValue(entData[i], exResult, loadResult);
            end
        end
        if (dispatchOk) begin
            entOp[dispatch.tag]        <= dispatch.op;
            entImm[dispatch.tag]       <= dispatch.imm;
            entBase[dispatch.tag].tag  <= dispatch.base.tag;
            entBase[dispatch.tag].data <= srcValue(dispatch.base, exResult, loadResult);
            entData[dispatch.tag].tag  <= dispatch.storeData.tag;
            entData[dispatch.tag].data <= srcValue(dispatch.storeData, exResult, loadResult);
        end
    end

endmodule

//--- source/lsuTop.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsuTop (
    input  logic             clk,
    input  logic             rstN,
    input  logic             flush,
    input  lsuPkg::dispatchS dispatch,
    input  lsuPkg::resultS   exResult,
    input  logic             commitValid,
    input  lsuPkg::tagT      commitTag,
    output lsuPkg::resultS   loadResult,
    output logic             full,
    output logic             bufEmpty,
    output logic             memIdle
);
    import lsuPkg::*;

    localparam int AddrW = $clog2(`LSU_MEM_WORDS);

    memReqS          memReq;
    logic            memBusy;
    logic            start;
    logic            done;
    logic            memEn;
    logic            memWe;
    logic [3:0]      memByteEn;
    logic [AddrW-1:0] memAddr;
    wordT            memWdata;
    wordT            memRdata;

    loadStoreBuffer i_loadStoreBuffer (
        .clk         (clk),
        .rstN        (rstN),
        .flush       (flush),
        .dispatch    (dispatch),
        .exResult    (exResult),
        .loadResult  (loadResult),
        .commitValid (commitValid),
        .commitTag   (commitTag),
        .memBusy     (memBusy),
        .memReq      (memReq),
        .full        (full),
        .bufEmpty    (bufEmpty)
    );

    memAccessFsm i_memAccessFsm (
        .clk        (clk),
        .rstN       (rstN),
        .flush      (flush),
        .memReq     (memReq),
        .done       (done),
        .start      (start),
        .memBusy    (memBusy),
        .memIdle    (memIdle),
        .memEn      (memEn),
        .memWe      (memWe),
        .memByteEn  (memByteEn),
        .memAddr    (memAddr),
        .memWdata   (memWdata),
        .memRdata   (memRdata),
        .loadResult (loadResult)
    );

    latencyTimer i_latencyTimer (
        .clk   (clk),
        .rstN  (rstN),
        .start (start),
        .done  (done)
    );

    dataMemory i_dataMemory (
        .clk       (clk),
        .memEn     (memEn),
        .memWe     (memWe),
        .memByteEn (memByteEn),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .memRdata  (memRdata)
    );

endmodule

//--- tests/lsu_props.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsuProps (
    input logic                    clk,
    input logic                    rstN,
    input lsuPkg::dispatchS        dispatch,
    input lsuPkg::memReqS          memReq,
    input logic                    memBusy,
    input logic                    full,
    input logic                    bufEmpty,
    input logic [`LSU_ENTRIES-1:0] occupied
);
    import lsuPkg::*;

    // FSM takes one request at a time
    reqNotWhileBusy: assert property (
        @(posedge clk) disable iff (!rstN) !(memReq.valid && memBusy)
    ) else $error("memReq valid while memBusy is high");

    dispatchToFreeTag: assert property (
        @(posedge clk) disable iff (!rstN)
        (dispatch.valid && dispatch.op != opNone) |-> !occupied[dispatch.tag]
    ) else $error("dispatch to occupied tag %0d", dispatch.tag);

    fullNotEmpty: assert property (
        @(posedge clk) disable iff (!rstN) !(full && bufEmpty)
    ) else $error("full and bufEmpty high together");

endmodule

//--- tests/lsuTb.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsuTb;
    import lsuPkg::*;

    localparam int MemAw   = $clog2(`LSU_MEM_WORDS);
    localparam int Timeout = 100;

    logic     clk;
    logic     rstN;
    logic     flush;
    dispatchS dispatch;
    resultS   exResult;
    logic     commitValid;
    tagT      commitTag;
    resultS   loadResult;
    logic     full;
    logic     bufEmpty;
    logic     memIdle;

    int    seed;
    string testName;
    int    mismatchCount;
    int    timeoutCount;
    int    unexpectedCount;

    wordT refMem  [`LSU_MEM_WORDS];
    wordT expData [`LSU_ENTRIES];
    logic [`LSU_ENTRIES-1:0] pending;

    // dispatched stores go into refMem on commit
    memOpE stOp   [`LSU_ENTRIES];
    wordT  stAddr [`LSU_ENTRIES];
    wordT  stData [`LSU_ENTRIES];

    lsuTop i_lsuTop (
        .clk         (clk),
        .rstN        (rstN),
        .flush       (flush),
        .dispatch    (dispatch),
        .exResult    (exResult),
        .commitValid (commitValid),
        .commitTag   (commitTag),
        .loadResult  (loadResult),
        .full        (full),
        .bufEmpty    (bufEmpty),
        .memIdle     (memIdle)
    );

    bind loadStoreBuffer lsuProps i_lsuProps (
        .clk      (clk),
        .rstN     (rstN),
        .dispatch (dispatch),
        .memReq   (memReq),
        .memBusy  (memBusy),
        .full     (full),
        .bufEmpty (bufEmpty),
        .occupied (occupied)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected load value with the lane picked by the low address bits
    function automatic wordT refLoad(memOpE op, wordT addr);
        wordT lane;
        lane = refMem[addr[MemAw+1:2]] >> (8 * addr[1:0]);
        case (op)
            opLb:    return {{24{lane[7]}}, lane[7:0]};
            opLbu:   return {24'd0, lane[7:0]};
            opLh:    return {{16{lane[15]}}, lane[15:0]};
            opLhu:   return {16'd0, lane[15:0]};
            default: return lane;
        endcase
    endfunction

    function automatic void writeRef(memOpE op, wordT addr, wordT data);
        case (op)
            opSb:    refMem[addr[MemAw+1:2]][8*addr[1:0] +: 8] = data[7:0];
            opSh:    refMem[addr[MemAw+1:2]][16*addr[1] +: 16] = data[15:0];
            default: refMem[addr[MemAw+1:2]] = data;
        endcase
    endfunction

    function automatic wordT randImm();
        return wordT'($random(seed)) & 32'h0000_00fc;
    endfunction

    function automatic srcS makeSrc(tagT tag, wordT data);
        srcS s;
        s.tag  = tag;
        s.data = data;
        return s;
    endfunction

    task automatic checkResult(resultS expected, resultS actual);
        if (actual !== expected) begin
            mismatchCount++;
            $display("Fail %s: expected tag %0d data %h, actual tag %0d data %h", testName,
                expected.tag, expected.data, actual.tag, actual.data);
        end
    endtask

    task automatic checkFlag(string flagName, logic expected, logic actual);
        if (actual !== expected) begin
            mismatchCount++;
            $display("Fail %s: %s expected %b, actual %b", testName, flagName, expected, actual);
        end
    endtask

    task automatic sendDispatch(memOpE op, tagT tag, wordT imm, srcS base, srcS storeData);
        @(negedge clk);
        dispatch = '{1'b1, op, tag, imm, base, storeData};
        @(negedge clk);
        dispatch = '0;
    endtask

    task automatic sendExResult(tagT tag, wordT data);
        @(negedge clk);
        exResult = '{1'b1, tag, data};
        @(negedge clk);
        exResult = '0;
    endtask

    task automatic sendCommit(tagT tag);
        @(negedge clk);
        commitValid = 1'b1;
        commitTag   = tag;
        writeRef(stOp[tag], stAddr[tag], stData[tag]);
        @(negedge clk);
        commitValid = 1'b0;
    endtask

    task automatic sendFlush();
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic expectLoad(tagT tag, wordT data);
        expData[tag] = data;
        pending[tag] = 1'b1;
    endtask

    task automatic waitResult(tagT tag);
        int n;
        n = 0;
        while (pending[tag] && n < Timeout) begin
            @(negedge clk);
            n++;
        end
        if (pending[tag]) begin
            timeoutCount++;
            pending[tag] = 1'b0;
            $display("Timeout in %s: no loadResult arrived for tag %0d", testName, tag);
        end
    endtask

    task automatic waitIdle();
        int n;
        n = 0;
        while (!(bufEmpty && memIdle) && n < Timeout) begin
            @(negedge clk);
            n++;
        end
        if (!(bufEmpty && memIdle)) begin
            timeoutCount++;
            $display("Timeout in %s: buffer and memory never became idle", testName);
        end
    endtask

    task automatic waitQuiet(int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk);
        end
    endtask

    task automatic doStore(memOpE op, tagT tag, wordT addr, wordT data);
        wordT imm;
        imm = randImm();
        stOp[tag]   = op;
        stAddr[tag] = addr;
        stData[tag] = data;
        sendDispatch(op, tag, imm, makeSrc('0, addr - imm), makeSrc('0, data));
    endtask

    task automatic storeCommitted(memOpE op, tagT tag, wordT addr, wordT data);
        doStore(op, tag, addr, data);
        sendCommit(tag);
        waitIdle();
    endtask

    task automatic doLoad(memOpE op, tagT tag, wordT addr);
        wordT imm;
        imm = randImm();
        expectLoad(tag, refLoad(op, addr));
        sendDispatch(op, tag, imm, makeSrc('0, addr - imm), '0);
        waitResult(tag);
    endtask

    task automatic storeThenLoad(tagT storeTag, tagT loadTag, wordT addr);
        storeCommitted(opSw, storeTag, addr, $random(seed));
        doLoad(opLw, loadTag, addr);
    endtask

    // every result must have been expected
    always @(posedge clk) begin
        resultS expected;
        if (rstN && loadResult.valid) begin
            if (pending[loadResult.tag]) begin
                expected = '{1'b1, loadResult.tag, expData[loadResult.tag]};
                checkResult(expected, loadResult);
                pending[loadResult.tag] = 1'b0;
            end else begin
                unexpectedCount++;
                $display("Unexpected loadResult for tag %0d in %s", loadResult.tag, testName);
            end
        end
    end

    initial begin
        wordT ptr;
        wordT imm;
        wordT baseVal;
        wordT byteAddr;
        wordT halfAddr;

        seed            = 32'h987c_0a62;
        mismatchCount   = 0;
        timeoutCount    = 0;
        unexpectedCount = 0;
        pending         = '0;
        testName        = "reset";
        for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
            refMem[i] = '0;
        end
        rstN        = 1'b0;
        flush       = 1'b0;
        dispatch    = '0;
        exResult    = '0;
        commitValid = 1'b0;
        commitTag   = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        checkFlag("full", 1'b0, full);
        checkFlag("bufEmpty", 1'b1, bufEmpty);
        checkFlag("memIdle", 1'b1, memIdle);
        checkFlag("loadResult.valid", 1'b0, loadResult.valid);

        testName = "storeThenLoad";
        storeThenLoad(tagT'(1), tagT'(2), 32'h040);

        // half store first so the byte lane keeps its sign bit
        testName = "widthExtension";
        byteAddr = 32'h100 | (wordT'($random(seed)) & 32'h3);
        halfAddr = 32'h100 | (wordT'($random(seed)) & 32'h2);
        storeCommitted(opSw, tagT'(1), 32'h100, $random(seed));
        storeCommitted(opSh, tagT'(2), halfAddr, $random(seed) | 32'h8000);
        storeCommitted(opSb, tagT'(3), byteAddr, $random(seed) | 32'h80);
        doLoad(opLb, tagT'(4), byteAddr);
        doLoad(opLbu, tagT'(5), byteAddr);
        doLoad(opLh, tagT'(6), halfAddr);
        doLoad(opLhu, tagT'(7), halfAddr);
        doLoad(opLw, tagT'(8), 32'h100);

        testName = "execWakeup";
        imm      = randImm();
        baseVal  = 32'h100 - imm;
        sendDispatch(opLw, tagT'(9), imm, makeSrc(tagT'(12), $random(seed)), '0);
        waitQuiet(20);
        checkFlag("bufEmpty", 1'b0, bufEmpty);
        expectLoad(tagT'(9), refLoad(opLw, baseVal + imm));
        sendExResult(tagT'(12), baseVal);
        waitResult(tagT'(9));

        // first load returns the pointer used by the second
        testName = "loadToLoad";
        ptr      = 32'h200 | (wordT'($random(seed)) & 32'hfc);
        imm      = randImm();
        storeCommitted(opSw, tagT'(1), 32'h080, ptr);
        storeCommitted(opSw, tagT'(2), ptr + imm, $random(seed));
        expectLoad(tagT'(10), refLoad(opLw, 32'h080));
        expectLoad(tagT'(11), refLoad(opLw, ptr + imm));
        sendDispatch(opLw, tagT'(10), 32'h0, makeSrc('0, 32'h080), '0);
        sendDispatch(opLw, tagT'(11), imm, makeSrc(tagT'(10), $random(seed)), '0);
        waitResult(tagT'(10));
        waitResult(tagT'(11));

        testName = "commitOrder";
        storeCommitted(opSw, tagT'(1), 32'h0c0, $random(seed));
        doStore(opSw, tagT'(2), 32'h0c0, $random(seed));
        doLoad(opLw, tagT'(3), 32'h0c0);
        sendCommit(tagT'(2));
        waitIdle();
        doLoad(opLw, tagT'(3), 32'h0c0);

        // every tag taken by a load waiting on tags 13 to 15
        testName = "flush";
        for (int i = 1; i < `LSU_ENTRIES; i++) begin
            sendDispatch(opLw, tagT'(i), randImm(), makeSrc(tagT'(13 + i % 3), $random(seed)),
                '0);
        end
        checkFlag("full", 1'b1, full);
        sendFlush();
        checkFlag("bufEmpty", 1'b1, bufEmpty);
        checkFlag("full", 1'b0, full);
        for (int i = 0; i < 3; i++) begin
            sendExResult(tagT'(13 + i), 32'h100);
        end
        waitQuiet(Timeout);
        checkFlag("bufEmpty", 1'b1, bufEmpty);
        testName = "afterFlush";
        storeThenLoad(tagT'(5), tagT'(6), 32'h300);

        $display("errors: %0d mismatches, %0d timeouts, %0d unexpected results",
            mismatchCount, timeoutCount, unexpectedCount);
        if (mismatchCount + timeoutCount + unexpectedCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // overall limit on simulated time
    initial begin
        #100000;
        $display("Simulation stopped at the time limit before all tests finished");
        $display("Test failed");
        $finish;
    end

endmodule

//--- build.f
+incdir+source
source/lsuPkg.sv
source/latencyTimer.sv
source/dataMemory.sv
source/memAccessFsm.sv
source/loadStoreBuffer.sv
source/lsuTop.sv
tests/lsu_props.sv
tests/lsuTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module lsuTb -f build.f -o lsuSim \
    && ./obj_dir/lsuSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
